/* hw/move_gen_pkg.sv */
`default_nettype none

package move_gen_pkg;

   typedef logic [3:0] piece_t;         // bit 3 black, bits 2:0 kind
   typedef piece_t [63:0] board_t;      // indexed by flat square number from a1

   localparam int BLACK_BIT = 3;

   localparam piece_t PIECE_EMPTY  = 4'd0;
   localparam piece_t PIECE_PAWN   = 4'd1;
   localparam piece_t PIECE_KNIGHT = 4'd2;
   localparam piece_t PIECE_BISHOP = 4'd3;
   localparam piece_t PIECE_ROOK   = 4'd4;
   localparam piece_t PIECE_QUEEN  = 4'd5;
   localparam piece_t PIECE_KING   = 4'd6;

   typedef union packed {
      logic [5:0] idx;
      struct packed {
         logic [2:0] row;
         logic [2:0] col;
      } rc;
   } square_u;

   typedef struct packed {
      logic   capture;
      logic   white_to_move;
      board_t board;
   } move_rec_t;

   typedef logic signed [2:0] step_t;

   // indexed by kind, then by direction
   localparam step_t DIR_ROW [8][8] = '{
      '{0, 0, 0, 0, 0, 0, 0, 0},
      '{0, 0, 0, 0, 0, 0, 0, 0},
      '{-2, -1, 1, 2, 2, 1, -1, -2},     // knight
      '{1, 1, -1, -1, 0, 0, 0, 0},       // bishop
      '{0, 0, 1, -1, 0, 0, 0, 0},        // rook
      '{-1, -1, -1, 0, 0, 1, 1, 1},      // queen
      '{-1, -1, -1, 0, 0, 1, 1, 1},      // king
      '{0, 0, 0, 0, 0, 0, 0, 0}
   };

   localparam step_t DIR_COL [8][8] = '{
      '{0, 0, 0, 0, 0, 0, 0, 0},
      '{0, 0, 0, 0, 0, 0, 0, 0},
      '{-1, -2, -2, -1, 1, 2, 2, 1},
      '{1, -1, 1, -1, 0, 0, 0, 0},
      '{1, -1, 0, 0, 0, 0, 0, 0},
      '{-1, 0, 1, -1, 1, -1, 0, 1},
      '{-1, 0, 1, -1, 1, -1, 0, 1},
      '{0, 0, 0, 0, 0, 0, 0, 0}
   };

   localparam logic [3:0] DIR_COUNT [8] = '{4'd0, 4'd0, 4'd8, 4'd4, 4'd4, 4'd8, 4'd8, 4'd0};
   localparam logic IS_SLIDER [8] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0};

endpackage

`default_nettype wire

/* hw/position_latch.sv */
`timescale 1ns/1ns
`default_nettype none

module position_latch import move_gen_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        load,
   input  board_t      board_in,
   input  logic        white_to_move_in,
   output board_t      board,
   output logic        white_to_move,
   output logic [63:0] candidates
);

   logic [63:0] next_candidates;

   // squares holding a non-pawn piece of the side to move
   always_comb
   begin
      for (int i = 0; i < 64; i++)
      begin
         next_candidates[i] = (board_in[i][BLACK_BIT] == ~white_to_move_in) &&
                              (board_in[i][2:0] != PIECE_EMPTY[2:0]) &&
                              (board_in[i][2:0] != PIECE_PAWN[2:0]);
      end
   end

   always_ff @(posedge clk)
   begin
      if (load)
      begin
         board <= board_in;
         white_to_move <= white_to_move_in;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         candidates <= '0;
      else if (load)
         candidates <= next_candidates;
   end

endmodule

`default_nettype wire

/* hw/square_scan.sv */
`timescale 1ns/1ns
`default_nettype none

module square_scan import move_gen_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        board_valid,
   input  logic        clear_moves,
   input  logic [63:0] candidates,
   input  logic        piece_done,
   output logic        load,
   output logic        store_clear,
   output logic        start,
   output square_u     from,
   output logic        moves_ready
);

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_LOAD,
      ST_SEEK,
      ST_WAIT,
      ST_DONE
   } state_t;

   state_t     state;
   logic [6:0] next_lo;       // lowest square not yet served
   logic       found;
   logic [5:0] found_idx;

   // lowest index wins the priority search
   always_comb
   begin
      found = 1'b0;
      found_idx = '0;
      for (int i = 63; i >= 0; i--)
      begin
         if (candidates[i] && (7'(i) >= next_lo))
         begin
            found = 1'b1;
            found_idx = 6'(i);
         end
      end
   end

   assign load = (state == ST_IDLE) && board_valid;
   assign store_clear = load;          // new position empties the store
   assign moves_ready = (state == ST_DONE);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= ST_IDLE;
         start <= 1'b0;
         next_lo <= '0;
      end
      else
      begin
         start <= 1'b0;
         case (state)
            ST_IDLE:
            begin
               if (board_valid)
                  state <= ST_LOAD;
            end
            ST_LOAD:
            begin
               next_lo <= '0;
               state <= ST_SEEK;
            end
            ST_SEEK:
            begin
               if (found)
               begin
                  start <= 1'b1;
                  next_lo <= {1'b0, found_idx} + 7'd1;
                  state <= ST_WAIT;
               end
               else
                  state <= ST_DONE;
            end
            ST_WAIT:
            begin
               if (piece_done)
                  state <= ST_SEEK;
            end
            ST_DONE:
            begin
               if (clear_moves)
                  state <= ST_IDLE;
            end
            default:
               state <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (state == ST_SEEK)
         from.idx <= found_idx;
   end

endmodule

`default_nettype wire

/* hw/move_stepper.sv */
`timescale 1ns/1ns
`default_nettype none

module move_stepper import move_gen_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  logic      start,
   input  square_u   from,
   input  board_t    board,
   input  logic      white_to_move,
   output logic      piece_done,
   output logic      move_wr,
   output move_rec_t move_rec
);

   typedef struct packed {
      logic    on_board;
      square_u sq;
   } target_t;

   logic       busy;
   piece_t     piece;
   square_u    origin;
   target_t    tgt;
   logic [2:0] dir_idx;
   logic [2:0] kind;
   logic [2:0] start_kind;
   piece_t     tpiece;
   logic       t_empty;
   logic       t_own;
   logic       go_on;
   logic       last_dir;
   board_t     next_board;

   // one rc-view step with a flag for leaving rows or cols 0..7
   function automatic target_t step_sq(square_u s, step_t dr, step_t dc);
      logic [3:0] r;
      logic [3:0] c;
      target_t    t;
      r = {1'b0, s.rc.row} + {dr[2], dr};
      c = {1'b0, s.rc.col} + {dc[2], dc};
      t.on_board = ~(r[3] | c[3]);
      t.sq.rc.row = r[2:0];
      t.sq.rc.col = c[2:0];
      return t;
   endfunction

   assign kind = piece[2:0];
   assign start_kind = board[from.idx][2:0];
   assign tpiece = board[tgt.sq.idx];
   assign t_empty = (tpiece[2:0] == PIECE_EMPTY[2:0]);
   assign t_own = !t_empty && (tpiece[BLACK_BIT] == ~white_to_move);
   assign go_on = IS_SLIDER[kind] && tgt.on_board && t_empty;   // ray continues
   assign last_dir = ({1'b0, dir_idx} + 4'd1) == DIR_COUNT[kind];

   always_comb
   begin
      next_board = board;
      next_board[origin.idx] = PIECE_EMPTY;
      next_board[tgt.sq.idx] = piece;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         busy <= 1'b0;
         piece_done <= 1'b0;
         move_wr <= 1'b0;
      end
      else
      begin
         piece_done <= 1'b0;
         move_wr <= 1'b0;
         if (start)
            busy <= 1'b1;
         else if (busy)
         begin
            move_wr <= tgt.on_board && !t_own;
            if (!go_on && last_dir)
            begin
               busy <= 1'b0;
               piece_done <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (start)
      begin
         piece <= board[from.idx];
         origin <= from;
         dir_idx <= '0;
         tgt <= step_sq(from, DIR_ROW[start_kind][0], DIR_COL[start_kind][0]);
      end
      else if (busy)
      begin
         move_rec.capture <= !t_empty;
         move_rec.white_to_move <= ~white_to_move;
         move_rec.board <= next_board;
         if (go_on)
            tgt <= step_sq(tgt.sq, DIR_ROW[kind][dir_idx], DIR_COL[kind][dir_idx]);
         else
         begin
            dir_idx <= dir_idx + 3'd1;
            tgt <= step_sq(origin, DIR_ROW[kind][dir_idx + 3'd1],
                           DIR_COL[kind][dir_idx + 3'd1]);
         end
      end
   end

endmodule

`default_nettype wire

/* hw/move_store.sv */
`timescale 1ns/1ns
`default_nettype none

module move_store import move_gen_pkg::*;
#(
   parameter int MAX_MOVES = 256
)
(
   input  logic                           clk,
   input  logic                           reset,
   input  logic                           store_clear,
   input  logic                           move_wr,
   input  move_rec_t                      move_rec,
   input  logic [$clog2(MAX_MOVES)-1:0]   move_index,
   output logic [$clog2(MAX_MOVES):0]     move_count,
   output move_rec_t                      move_out,
   output logic                           move_ready
);

   localparam int IW = $clog2(MAX_MOVES);

   move_rec_t         mem [MAX_MOVES];
   logic [IW-1:0]     move_index_r;
   logic              wr_en;

   assign wr_en = move_wr && (move_count < MAX_MOVES);   // drop when full

   always_ff @(posedge clk)
   begin
      if (wr_en)
         mem[move_count[IW-1:0]] <= move_rec;
      move_out <= mem[move_index];
      move_index_r <= move_index;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         move_count <= '0;
         move_ready <= 1'b0;
      end
      else
      begin
         move_ready <= (move_index == move_index_r);   // index held two edges
         if (store_clear)
            move_count <= '0;
         else if (wr_en)
            move_count <= move_count + 1'b1;
      end
   end

endmodule

`default_nettype wire

/* hw/move_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module move_gen import move_gen_pkg::*;
#(
   parameter int MAX_MOVES = 256
)
(
   input  logic                           clk,
   input  logic                           reset,
   input  logic                           board_valid,
   input  board_t                         board_in,
   input  logic                           white_to_move_in,
   input  logic [$clog2(MAX_MOVES)-1:0]   move_index,
   input  logic                           clear_moves,
   output logic                           moves_ready,
   output logic [$clog2(MAX_MOVES):0]     move_count,
   output move_rec_t                      move_out,
   output logic                           move_ready
);

   board_t      board;
   logic        white_to_move;
   logic [63:0] candidates;
   logic        load;
   logic        store_clear;
   logic        start;
   square_u     from;
   logic        piece_done;
   logic        move_wr;
   move_rec_t   move_rec;

   position_latch u_position_latch (
      .clk              (clk),
      .reset            (reset),
      .load             (load),
      .board_in         (board_in),
      .white_to_move_in (white_to_move_in),
      .board            (board),
      .white_to_move    (white_to_move),
      .candidates       (candidates)
   );

   square_scan u_square_scan (
      .clk         (clk),
      .reset       (reset),
      .board_valid (board_valid),
      .clear_moves (clear_moves),
      .candidates  (candidates),
      .piece_done  (piece_done),
      .load        (load),
      .store_clear (store_clear),
      .start       (start),
      .from        (from),
      .moves_ready (moves_ready)
   );

   move_stepper u_move_stepper (
      .clk           (clk),
      .reset         (reset),
      .start         (start),
      .from          (from),
      .board         (board),
      .white_to_move (white_to_move),
      .piece_done    (piece_done),
      .move_wr       (move_wr),
      .move_rec      (move_rec)
   );

   move_store #(
      .MAX_MOVES (MAX_MOVES)
   ) u_move_store (
      .clk         (clk),
      .reset       (reset),
      .store_clear (store_clear),
      .move_wr     (move_wr),
      .move_rec    (move_rec),
      .move_index  (move_index),
      .move_count  (move_count),
      .move_out    (move_out),
      .move_ready  (move_ready)
   );

endmodule

`default_nettype wire

/* bench/move_gen_properties.sv */
`timescale 1ns/1ns
`default_nettype none

module move_gen_properties
#(
   parameter int MAX_MOVES = 256
)
(
   input logic                       clk,
   input logic                       reset,
   input logic                       moves_ready,
   input logic                       clear_moves,
   input logic                       move_wr,
   input logic [$clog2(MAX_MOVES):0] move_count
);

   int fail_count = 0;   // read by the testbench at the end

   no_write_when_ready: assert property (@(posedge clk) disable iff (reset)
      moves_ready |-> !move_wr)
   else
   begin
      $error("move_wr seen while moves_ready is high");
      fail_count++;
   end

   ready_falls_on_clear: assert property (@(posedge clk) disable iff (reset)
      moves_ready && clear_moves |=> !moves_ready)
   else
   begin
      $error("moves_ready still high after clear_moves");
      fail_count++;
   end

   count_stable_when_ready: assert property (@(posedge clk) disable iff (reset)
      moves_ready && !clear_moves |=> $stable(move_count))
   else
   begin
      $error("move_count changed while moves_ready is high");
      fail_count++;
   end

   count_in_range: assert property (@(posedge clk) disable iff (reset)
      move_count <= MAX_MOVES)
   else
   begin
      $error("move_count above memory depth");
      fail_count++;
   end

endmodule

bind move_gen move_gen_properties #(
   .MAX_MOVES (MAX_MOVES)
) u_move_gen_properties (
   .clk         (clk),
   .reset       (reset),
   .moves_ready (moves_ready),
   .clear_moves (clear_moves),
   .move_wr     (move_wr),
   .move_count  (move_count)
);

`default_nettype wire

/* bench/tb_move_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_move_gen import move_gen_pkg::*;
();

   localparam int MAX_MOVES = 256;
   localparam int IW = $clog2(MAX_MOVES);
   localparam int CW = IW + 1;
   localparam int NUM_TESTS = 6;
   localparam int SCAN_CYCLES = 64 * 30;
   localparam int WATCHDOG_NS = NUM_TESTS * (SCAN_CYCLES + 300) * 10;

   logic          clk = 1'b0;
   logic          reset;
   logic          board_valid;
   board_t        board_in;
   logic          white_to_move_in;
   logic [IW-1:0] move_index;
   logic          clear_moves;
   logic          moves_ready;
   logic [CW-1:0] move_count;
   move_rec_t     move_out;
   logic          move_ready;

   int        errors = 0;
   int        checks = 0;
   move_rec_t exp_q[$];   // expected records in generation order

   move_gen #(
      .MAX_MOVES (MAX_MOVES)
   ) u_move_gen (
      .clk              (clk),
      .reset            (reset),
      .board_valid      (board_valid),
      .board_in         (board_in),
      .white_to_move_in (white_to_move_in),
      .move_index       (move_index),
      .clear_moves      (clear_moves),
      .moves_ready      (moves_ready),
      .move_count       (move_count),
      .move_out         (move_out),
      .move_ready       (move_ready)
   );

   always #5 clk = ~clk;

   task automatic check_count(input string name, input logic [CW-1:0] got,
                              input logic [CW-1:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("[FAIL] %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_move(input string name, input move_rec_t got, input move_rec_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("[FAIL] %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("[FAIL] %s got %h expected %h", name, got, exp);
      end
   endtask

   function automatic piece_t as_black(piece_t p);
      return {1'b1, p[2:0]};
   endfunction

   // squares ascending, directions in table order, targets nearest first
   task automatic build_expected(input board_t b, input logic wtm);
      int        dr[8];
      int        dc[8];
      int        n;
      int        r;
      int        c;
      piece_t    p;
      piece_t    t;
      logic      slider;
      move_rec_t m;
      exp_q.delete();
      for (int sq = 0; sq < 64; sq++)
      begin
         p = b[sq];
         if (p[2:0] == 3'd0 || p[2:0] == 3'd1 || p[3] == wtm)
            continue;                      // empty, pawn or not the mover
         n = 0;
         dr = '{0, 0, 0, 0, 0, 0, 0, 0};
         dc = '{0, 0, 0, 0, 0, 0, 0, 0};
         case (p[2:0])
            3'd2:
            begin
               dr = '{-2, -1, 1, 2, 2, 1, -1, -2};
               dc = '{-1, -2, -2, -1, 1, 2, 2, 1};
               n = 8;
            end
            3'd3:
            begin
               dr = '{1, 1, -1, -1, 0, 0, 0, 0};
               dc = '{1, -1, 1, -1, 0, 0, 0, 0};
               n = 4;
            end
            3'd4:
            begin
               dr = '{0, 0, 1, -1, 0, 0, 0, 0};
               dc = '{1, -1, 0, 0, 0, 0, 0, 0};
               n = 4;
            end
            default:
            begin
               for (int i = -1; i <= 1; i++)
               begin
                  for (int j = -1; j <= 1; j++)
                  begin
                     if (i != 0 || j != 0)
                     begin
                        dr[n] = i;
                        dc[n] = j;
                        n++;
                     end
                  end
               end
            end
         endcase
         slider = (p[2:0] == 3'd3) || (p[2:0] == 3'd4) || (p[2:0] == 3'd5);
         for (int d = 0; d < n; d++)
         begin
            r = sq / 8 + dr[d];
            c = sq % 8 + dc[d];
            while (r >= 0 && r < 8 && c >= 0 && c < 8)
            begin
               t = b[r * 8 + c];
               if (t[2:0] != 3'd0 && t[3] == p[3])
                  break;                   // own piece blocks
               m.capture = (t[2:0] != 3'd0);
               m.white_to_move = !wtm;
               m.board = b;
               m.board[sq] = PIECE_EMPTY;
               m.board[r * 8 + c] = p;
               exp_q.push_back(m);
               if (m.capture || !slider)
                  break;
               r += dr[d];
               c += dc[d];
            end
         end
      end
   endtask

   task automatic load_position(input board_t b, input logic wtm);
      build_expected(b, wtm);
      @(posedge clk);
      #1;
      board_in = b;
      white_to_move_in = wtm;
      board_valid = 1'b1;
      @(posedge clk);
      #1;
      board_valid = 1'b0;
   endtask

   task automatic wait_moves_ready();
      int n;
      n = 0;
      while (!moves_ready && n < SCAN_CYCLES)
      begin
         @(posedge clk);
         #1;
         n++;
      end
      if (!moves_ready)
      begin
         errors++;
         $display("moves_ready did not rise within %0d cycles", SCAN_CYCLES);
      end
   endtask

   task automatic read_move(input logic [IW-1:0] idx, output move_rec_t rec);
      logic changed;
      changed = (idx != move_index);
      @(posedge clk);
      #1;
      move_index = idx;
      @(posedge clk);
      #1;
      rec = move_out;
      if (changed)
         check_bit("move_ready", move_ready, 1'b0);
      @(posedge clk);
      #1;
      check_bit("move_ready", move_ready, 1'b1);
   endtask

   task automatic clear_result();
      @(posedge clk);
      #1;
      clear_moves = 1'b1;
      @(posedge clk);
      #1;
      clear_moves = 1'b0;
      check_bit("moves_ready", moves_ready, 1'b0);
   endtask

   task automatic run_position(input board_t b, input logic wtm);
      load_position(b, wtm);
      wait_moves_ready();
      check_count("move_count", move_count, CW'(exp_q.size()));
   endtask

   task automatic check_all_in_order(output int captures);
      move_rec_t rec;
      captures = 0;
      for (int i = 0; i < exp_q.size(); i++)
      begin
         read_move(IW'(i), rec);
         check_move("move_out", rec, exp_q[i]);
         if (rec.capture)
            captures++;
      end
   endtask

   function automatic board_t rook_board();
      board_t b;
      b = '0;
      b[27] = PIECE_ROOK;                  // d4
      return b;
   endfunction

   function automatic board_t queen_board();
      board_t b;
      b = '0;
      b[27] = PIECE_QUEEN;                 // d4
      b[43] = PIECE_KNIGHT;                // d6 blocks the queen upward
      b[29] = as_black(PIECE_BISHOP);      // f4 taken by the queen
      return b;
   endfunction

   task automatic test_lone_rook();
      int caps;
      run_position(rook_board(), 1'b1);
      check_count("move_count", move_count, CW'(14));
      check_all_in_order(caps);
      check_count("captures", CW'(caps), CW'(0));
      clear_result();
   endtask

   task automatic test_knight_king();
      board_t b;
      int     caps;
      b = '0;
      b[0] = PIECE_KNIGHT;                 // a1
      b[63] = PIECE_KING;                  // h8
      b[12] = PIECE_PAWN;
      b[35] = as_black(PIECE_ROOK);
      b[44] = as_black(PIECE_KNIGHT);
      run_position(b, 1'b1);
      check_count("move_count", move_count, CW'(5));
      check_all_in_order(caps);
      check_count("captures", CW'(caps), CW'(0));
      clear_result();
   endtask

   task automatic test_queen_blocked();
      int caps;
      run_position(queen_board(), 1'b1);
      check_all_in_order(caps);
      check_count("captures", CW'(caps), CW'(1));
      clear_result();
   endtask

   task automatic test_black_to_move();
      int caps;
      run_position(queen_board(), 1'b0);   // only the bishop moves
      check_all_in_order(caps);
      check_count("captures", CW'(caps), CW'(1));
      clear_result();
   endtask

   task automatic test_no_moves();
      board_t b;
      b = '0;
      for (int i = 8; i < 16; i++)
         b[i] = PIECE_PAWN;
      b[60] = as_black(PIECE_KING);
      run_position(b, 1'b1);
      check_count("move_count", move_count, CW'(0));
      clear_result();
   endtask

   task automatic test_readout();
      int        order[$];
      int        j;
      int        tmp;
      int        caps;
      move_rec_t rec;
      run_position(queen_board(), 1'b1);
      for (int i = 0; i < exp_q.size(); i++)
         order.push_back(i);
      for (int i = order.size() - 1; i > 0; i--)
      begin
         j = int'($urandom % (i + 1));
         tmp = order[i];
         order[i] = order[j];
         order[j] = tmp;
      end
      foreach (order[k])
      begin
         read_move(IW'(order[k]), rec);
         check_move("move_out", rec, exp_q[order[k]]);
      end
      clear_result();
      run_position(rook_board(), 1'b1);    // second result replaces the first
      check_all_in_order(caps);
      check_count("captures", CW'(caps), CW'(0));
      clear_result();
   endtask

   initial
   begin
      #(WATCHDOG_NS);
      $display("watchdog expired after %0d ns, the run stalled", WATCHDOG_NS);
      $display("*** TEST FAILED ***");
      $finish;
   end

   initial
   begin
      void'($urandom(32'h6b8a_4fd4));
      reset = 1'b1;
      board_valid = 1'b0;
      board_in = '0;
      white_to_move_in = 1'b1;
      move_index = '0;
      clear_moves = 1'b0;
      repeat (4) @(posedge clk);
      #1;
      reset = 1'b0;
      check_bit("moves_ready", moves_ready, 1'b0);
      check_count("move_count", move_count, '0);
      test_lone_rook();
      test_knight_king();
      test_queen_blocked();
      test_black_to_move();
      test_no_moves();
      test_readout();
      errors += u_move_gen.u_move_gen_properties.fail_count;   // assertion failures
      $display("checks: %0d  errors: %0d", checks, errors);
      if (errors == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

/* verilog.f */
hw/move_gen_pkg.sv
hw/position_latch.sv
hw/square_scan.sv
hw/move_stepper.sv
hw/move_store.sv
hw/move_gen.sv
bench/move_gen_properties.sv
bench/tb_move_gen.sv

/* Makefile */
VERILATOR = verilator
TOP       = tb_move_gen
FILELIST  = verilog.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = *** TEST PASSED ***
FLAGS     = --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir $(BUILD_DIR)
RUN_FLAGS = +verilator+error+limit+1000

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
